// ==== verilog.f ====
verilog/sdram_pkg.sv
verilog/ctrl_pkg.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_sequencer.sv
verilog/sdram_pin_driver.sv
verilog/sdram_ctrl_top.sv
verification/tb_clock_gen.sv
verification/tb_sdram_model.sv
verification/tb_sdram_ctrl.sv

// ==== Makefile ====
# Verilator flow for the SDR SDRAM controller

VERILATOR  ?= verilator
TOP        := tb_sdram_ctrl
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_sdram_ctrl.sv ====
// ----------------------------------------------------------------------
// Testbench for the SDR SDRAM controller
// Checks the power-up order, single and random accesses against a
// shadow memory, and the command log for timing and refresh rules
// Stimulus changes on the falling clock edge
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_sdram_ctrl;

    localparam int N_RANDOM       = 60;
    localparam int N_POOL         = 8;
    localparam int TIMEOUT_CYCLES = (ctrl_pkg::T_INIT_WAIT + N_RANDOM * 40) * 2;
    localparam int MAX_REF_GAP    = ctrl_pkg::T_REF_INTERVAL + ctrl_pkg::T_RCD
                                  + ctrl_pkg::T_RP + sdram_pkg::CAS_LATENCY + 6;

    typedef struct packed {
        int                     cyc;
        sdram_pkg::sdram_pins_t pins;
    } log_entry_t;

    typedef struct packed {
        logic                         check;
        logic [sdram_pkg::DATA_W-1:0] data;
    } expect_t;

    logic                         clk;
    logic                         reset;
    logic                         req;
    ctrl_pkg::host_req_t          request;
    logic                         done;
    logic [sdram_pkg::DATA_W-1:0] rd_data;
    sdram_pkg::sdram_pins_t       sdram_pins;
    wire  [sdram_pkg::DATA_W-1:0] dq;

    integer                       seed;
    int                           errors = 0;
    int                           n_req = 0;
    int                           n_done = 0;
    int                           cyc = 0;
    int                           release_cyc;
    int                           timeout_cyc;
    log_entry_t                   cmd_log [$];
    expect_t                      exp_q [$];
    ctrl_pkg::host_req_t          sent_q [$];
    logic [sdram_pkg::DATA_W-1:0] shadow [bit [23:0]];
    ctrl_pkg::host_addr_t         pool [N_POOL];

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    tb_sdram_model i_sdram_model (
        .clk  (clk),
        .pins (sdram_pins),
        .dq   (dq)
    );

    sdram_ctrl_top i_sdram_ctrl_top (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .request    (request),
        .done       (done),
        .rd_data    (rd_data),
        .sdram_pins (sdram_pins),
        .dq         (dq)
    );

    // ------------------------------------------------------------------
    // Checking helpers and reference model
    // ------------------------------------------------------------------
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Protocol error at %0t ns: %s", $time, msg);
    endtask

    // A2:0 burst length 1, A3 sequential, A6:4 CAS latency,
    // A8:7 standard operation, A9 single-location writes
    function automatic logic [12:0] ref_mode_word();
        return {3'b000, 1'b1, 2'b00, 3'(sdram_pkg::CAS_LATENCY), 1'b0, 3'b000};
    endfunction

    function automatic logic [15:0] ref_read(input ctrl_pkg::host_addr_t addr);
        return shadow[addr];
    endfunction

    // Holds req until done, then drops it
    task automatic do_access(input logic wr, input ctrl_pkg::host_addr_t addr,
                             input logic [15:0] data);
        expect_t e;
        e.check = !wr && (shadow.exists(addr) != 0);
        e.data  = e.check ? ref_read(addr) : '0;
        exp_q.push_back(e);
        if (wr)
            shadow[addr] = data;
        request.wr      = wr;
        request.addr    = addr;
        request.wr_data = data;
        req             = 1'b1;
        sent_q.push_back(request);
        n_req++;
        @(negedge clk);
        while (!done) @(negedge clk);
        req = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Command monitor and read data compare
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        log_entry_t e;
        cyc = cyc + 1;
        if (sdram_pins.cmd != sdram_pkg::NOP && sdram_pins.cmd != sdram_pkg::INHIBIT) begin
            e.cyc  = cyc;
            e.pins = sdram_pins;
            cmd_log.push_back(e);
        end
    end

    always @(negedge clk) begin
        expect_t e;
        if (done) begin
            n_done++;
            if (exp_q.size() == 0) begin
                report_error("done pulsed with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                if (e.check)
                    check_value(32'(rd_data), 32'(e.data), "read data");
            end
        end
    end

    // ------------------------------------------------------------------
    // Command log checks
    // ------------------------------------------------------------------
    task automatic check_init_order();
        if (cmd_log.size() < 4) begin
            report_error("fewer than four commands after reset");
            return;
        end
        check_value(32'(cmd_log[0].cyc - release_cyc), 32'(ctrl_pkg::T_INIT_WAIT + 1),
                    "power-up wait");
        check_value(32'(cmd_log[0].pins.cmd), 32'(sdram_pkg::PRECHARGE), "init command 1");
        check_value(32'(cmd_log[0].pins.a.col.auto_precharge), 32'(1), "init PRECHARGE A10");
        check_value(32'(cmd_log[1].pins.cmd), 32'(sdram_pkg::AUTO_REFRESH), "init command 2");
        check_value(32'(cmd_log[2].pins.cmd), 32'(sdram_pkg::AUTO_REFRESH), "init command 3");
        check_value(32'(cmd_log[3].pins.cmd), 32'(sdram_pkg::LOAD_MODE), "init command 4");
        check_value(32'(cmd_log[3].pins.a.mode), 32'(ref_mode_word()), "mode register word");
        if (cmd_log[1].cyc - cmd_log[0].cyc < ctrl_pkg::T_RP)
            report_error("init PRECHARGE to REFRESH gap below tRP");
        if (cmd_log[2].cyc - cmd_log[1].cyc < ctrl_pkg::T_RFC)
            report_error("init REFRESH to REFRESH gap below tRFC");
        if (cmd_log[3].cyc - cmd_log[2].cyc < ctrl_pkg::T_RFC)
            report_error("init REFRESH to LOAD MODE gap below tRFC");
        if (cmd_log.size() > 4 && cmd_log[4].cyc - cmd_log[3].cyc < ctrl_pkg::T_MRD)
            report_error("command after LOAD MODE within tMRD");
    endtask

    task automatic check_access_rules();
        log_entry_t          e;
        ctrl_pkg::host_req_t r;
        logic                row_open;
        int                  act_cyc;
        int                  wr_cyc;
        int                  rd_cyc;
        row_open = 1'b0;
        act_cyc  = 0;
        wr_cyc   = -1;
        rd_cyc   = -1;
        for (int i = 4; i < cmd_log.size(); i++) begin
            e = cmd_log[i];
            case (e.pins.cmd)
                sdram_pkg::ACTIVE: begin
                    if (row_open)
                        report_error($sformatf("ACTIVE at cycle %0d with a row open", e.cyc));
                    if (sent_q.size() == 0) begin
                        report_error($sformatf("ACTIVE at cycle %0d with no request", e.cyc));
                    end else begin
                        check_value(32'(e.pins.ba), 32'(sent_q[0].addr.bank), "ACTIVE bank");
                        check_value(32'(e.pins.a.row), 32'(sent_q[0].addr.row), "ACTIVE row");
                    end
                    row_open = 1'b1;
                    act_cyc  = e.cyc;
                end
                sdram_pkg::READ, sdram_pkg::WRITE: begin
                    if (!row_open)
                        report_error($sformatf("column access at cycle %0d, no row", e.cyc));
                    else if (e.cyc - act_cyc < ctrl_pkg::T_RCD)
                        report_error($sformatf("column access at cycle %0d within tRCD", e.cyc));
                    if (sent_q.size() == 0) begin
                        report_error($sformatf("column access at cycle %0d, no request", e.cyc));
                    end else begin
                        r = sent_q.pop_front();
                        check_value(32'(e.pins.cmd == sdram_pkg::WRITE), 32'(r.wr), "access type");
                        check_value(32'(e.pins.ba), 32'(r.addr.bank), "column bank");
                        check_value(32'(e.pins.a.col.col), 32'(r.addr.col), "column address");
                    end
                    if (e.pins.cmd == sdram_pkg::WRITE)
                        wr_cyc = e.cyc;
                    else
                        rd_cyc = e.cyc;
                end
                sdram_pkg::PRECHARGE: begin
                    if (!e.pins.a.col.auto_precharge)
                        report_error($sformatf("PRECHARGE at cycle %0d without A10", e.cyc));
                    if (wr_cyc >= 0 && e.cyc - wr_cyc < ctrl_pkg::T_WR)
                        report_error($sformatf("PRECHARGE at cycle %0d within tWR", e.cyc));
                    if (rd_cyc >= 0 && e.cyc - rd_cyc < sdram_pkg::CAS_LATENCY + 1)
                        report_error($sformatf("PRECHARGE at cycle %0d cuts a read", e.cyc));
                    row_open = 1'b0;
                    wr_cyc   = -1;
                    rd_cyc   = -1;
                end
                sdram_pkg::AUTO_REFRESH: begin
                    if (row_open)
                        report_error($sformatf("REFRESH at cycle %0d with a row open", e.cyc));
                end
                default: begin
                    report_error($sformatf("unexpected command at cycle %0d", e.cyc));
                end
            endcase
        end
        if (sent_q.size() != 0)
            report_error("some requests never reached the pins");
    endtask

    task automatic check_refresh_rate();
        int n_ref;
        int last;
        int elapsed;
        n_ref = 0;
        last  = -1;
        if (cmd_log.size() < 4)
            return;
        for (int i = 4; i < cmd_log.size(); i++) begin
            if (cmd_log[i].pins.cmd == sdram_pkg::AUTO_REFRESH) begin
                n_ref++;
                if (last >= 0 && cmd_log[i].cyc - last > MAX_REF_GAP)
                    report_error($sformatf("refresh gap of %0d cycles before cycle %0d",
                                           cmd_log[i].cyc - last, cmd_log[i].cyc));
                last = cmd_log[i].cyc;
            end
        end
        elapsed = cyc - cmd_log[3].cyc;
        if (n_ref < elapsed / ctrl_pkg::T_REF_INTERVAL - 1)
            report_error($sformatf("%0d refreshes in %0d cycles is too few", n_ref, elapsed));
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int idle;
        int pick;
        seed    = 32'h630b;
        req     = 1'b0;
        request = '0;

        // Pin state while reset is held
        @(posedge clk);
        @(negedge clk);
        check_value(32'(sdram_pins.cmd), 32'(sdram_pkg::INHIBIT), "pins in reset");
        check_value(32'(sdram_pins.cke), 32'(1), "cke in reset");
        check_value(32'(done), 32'(0), "done in reset");

        do @(posedge clk); while (reset);
        release_cyc = cyc;

        // Pool spans all four banks with random rows and columns
        for (int i = 0; i < N_POOL; i++) begin
            pool[i].row  = 13'($random(seed));
            pool[i].bank = 2'(i);
            pool[i].col  = 9'($random(seed));
        end

        @(negedge clk);
        do_access(1'b1, pool[0], 16'($random(seed)));
        do_access(1'b0, pool[0], '0);

        for (int n = 0; n < N_RANDOM; n++) begin
            idle = $unsigned($random(seed)) % 4;
            pick = $unsigned($random(seed)) % N_POOL;
            repeat (idle) @(negedge clk);
            do_access(1'($random(seed)), pool[pick], 16'($random(seed)));
        end

        // Idle tail so periodic refresh shows in the log
        repeat (2 * ctrl_pkg::T_REF_INTERVAL) @(negedge clk);
        @(posedge clk);

        check_init_order();
        check_access_rules();
        check_refresh_rate();
        check_value(32'(n_done), 32'(n_req), "done pulses per request");
        if (exp_q.size() != 0)
            report_error("requests still waiting for done at the end");

        $display("Summary: %0d errors, %0d requests, %0d done pulses, %0d commands",
                 errors, n_req, n_done, cmd_log.size());
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        timeout_cyc = 0;
        while (timeout_cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            timeout_cyc++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verification/tb_sdram_model.sv ====
// ----------------------------------------------------------------------
// Behavioral SDR SDRAM for the controller testbench
// Decodes the registered pins on each rising edge, stores WRITE data
// and drives READ data onto DQ after the CAS latency
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_sdram_model (
    input  logic                         clk,
    input  sdram_pkg::sdram_pins_t       pins,
    inout  wire  [sdram_pkg::DATA_W-1:0] dq
);

    localparam int CL = sdram_pkg::CAS_LATENCY;

    logic [sdram_pkg::DATA_W-1:0] mem [bit [23:0]];
    logic [sdram_pkg::ROW_W-1:0]  open_row [4];
    logic [CL-1:0]                rd_valid = '0;
    logic [sdram_pkg::DATA_W-1:0] rd_word [CL];

    // Never-written words read back a pattern of the whole address
    function automatic logic [15:0] fill_word(input bit [23:0] key);
        return key[15:0] ^ {key[23:16], key[23:16]};
    endfunction

    always @(posedge clk) begin
        bit [23:0] key;
        key = {open_row[pins.ba], pins.ba, pins.a.col.col};

        // Read data leaves the array now and reaches DQ CL-1 cycles later
        rd_valid   <= {rd_valid[CL-2:0], pins.cmd == sdram_pkg::READ};
        rd_word[0] <= mem.exists(key) ? mem[key] : fill_word(key);
        for (int i = 1; i < CL; i++) begin
            rd_word[i] <= rd_word[i-1];
        end

        case (pins.cmd)
            sdram_pkg::ACTIVE: open_row[pins.ba] <= pins.a.row;
            sdram_pkg::WRITE:  mem[key] = dq;
            default: ;
        endcase
    end

    assign dq = rd_valid[CL-1] ? rd_word[CL-1] : 'z;

endmodule

// ==== verification/tb_clock_gen.sv ====
// ----------------------------------------------------------------------
// Clock and reset for the SDRAM controller testbench
// 4 ns clock, reset held high for the first four cycles
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the flops
    initial begin
        reset = 1'b1;
        #(4 * PERIOD);
        reset = 1'b0;
    end

endmodule

// ==== verilog/sdram_ctrl_top.sv ====
// ----------------------------------------------------------------------
// SDR SDRAM controller top level
// Host holds req with a stable request until done pulses; read data
// is valid in the done cycle. Pins and DQ connect to the device
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sdram_ctrl_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req,
    input  ctrl_pkg::host_req_t          request,
    output logic                         done,
    output logic [sdram_pkg::DATA_W-1:0] rd_data,
    output sdram_pkg::sdram_pins_t       sdram_pins,
    inout  wire  [sdram_pkg::DATA_W-1:0] dq
);

    logic                         init_done;
    logic                         refresh_owed;
    logic                         refresh_taken;
    sdram_pkg::sdram_pins_t       next_pins;
    logic                         issue_read;
    logic                         drive_dq;
    logic [sdram_pkg::DATA_W-1:0] write_data;
    logic                         read_done;
    logic                         write_done;

    sdram_refresh_timer i_refresh_timer (
        .clk           (clk),
        .reset         (reset),
        .init_done     (init_done),
        .refresh_taken (refresh_taken),
        .refresh_owed  (refresh_owed)
    );

    sdram_sequencer i_sequencer (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .request       (request),
        .refresh_owed  (refresh_owed),
        .refresh_taken (refresh_taken),
        .init_done     (init_done),
        .next_pins     (next_pins),
        .issue_read    (issue_read),
        .drive_dq      (drive_dq),
        .write_data    (write_data),
        .read_done     (read_done)
    );

    sdram_pin_driver i_pin_driver (
        .clk        (clk),
        .reset      (reset),
        .next_pins  (next_pins),
        .issue_read (issue_read),
        .drive_dq   (drive_dq),
        .write_data (write_data),
        .sdram_pins (sdram_pins),
        .dq         (dq),
        .read_done  (read_done),
        .rd_data    (rd_data)
    );

    // Write completes in the cycle the WRITE is on the pins
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            write_done <= 1'b0;
        else
            write_done <= drive_dq;
    end

    assign done = read_done | write_done;

endmodule

// ==== verilog/sdram_pin_driver.sv ====
// ----------------------------------------------------------------------
// Pin stage of the SDRAM controller
// Registers command and address onto the device pins, drives DQ in
// the WRITE cycle and captures read data CAS latency after READ
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sdram_pin_driver (
    input  logic                         clk,
    input  logic                         reset,
    input  sdram_pkg::sdram_pins_t       next_pins,
    input  logic                         issue_read,
    input  logic                         drive_dq,
    input  logic [sdram_pkg::DATA_W-1:0] write_data,
    output sdram_pkg::sdram_pins_t       sdram_pins,
    inout  wire  [sdram_pkg::DATA_W-1:0] dq,
    output logic                         read_done,
    output logic [sdram_pkg::DATA_W-1:0] rd_data
);

    logic                              dq_en;
    logic [sdram_pkg::DATA_W-1:0]      dq_out;
    // Bit k set while the READ has been on the pins for k cycles
    logic [sdram_pkg::CAS_LATENCY:0]   rd_pipe;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sdram_pins <= '{cke: 1'b1, cmd: sdram_pkg::INHIBIT, ba: '0, a: '0};
            dq_en      <= 1'b0;
            rd_pipe    <= '0;
            read_done  <= 1'b0;
        end else begin
            sdram_pins <= next_pins;
            dq_en      <= drive_dq;
            rd_pipe    <= {rd_pipe[sdram_pkg::CAS_LATENCY-1:0], issue_read};
            read_done  <= rd_pipe[sdram_pkg::CAS_LATENCY];
        end
    end

    always_ff @(posedge clk) begin
        dq_out <= write_data;
        // Sample at the end of the cycle the device drives data
        if (rd_pipe[sdram_pkg::CAS_LATENCY])
            rd_data <= dq;
    end

    assign dq = dq_en ? dq_out : 'z;

    // No bus turnaround while read data is still on its way
    a_no_drive_in_read: assert property (@(posedge clk) disable iff (reset)
        dq_en |-> (rd_pipe == '0));

endmodule

// ==== verilog/sdram_sequencer.sv ====
// ----------------------------------------------------------------------
// Command sequencer for the SDRAM controller
// Runs power-up init, then serves refreshes and single closed-page
// accesses. Produces the next pin state one cycle ahead of the pins
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sdram_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req,
    input  ctrl_pkg::host_req_t          request,
    input  logic                         refresh_owed,
    output logic                         refresh_taken,
    output logic                         init_done,
    output sdram_pkg::sdram_pins_t       next_pins,
    output logic                         issue_read,
    output logic                         drive_dq,
    output logic [sdram_pkg::DATA_W-1:0] write_data,
    input  logic                         read_done
);

    ctrl_pkg::seq_state_e state;
    ctrl_pkg::seq_state_e next_state;
    ctrl_pkg::wait_t      wait_cnt;
    ctrl_pkg::wait_t      wait_load;
    logic                 wait_done;
    logic                 first;
    logic                 row_open;
    ctrl_pkg::host_req_t  cur;

    assign wait_done = (wait_cnt == ctrl_pkg::wait_t'(1));

    // ------------------------------------------------------------------
    // State transitions
    // ------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ctrl_pkg::INIT_WAIT:      if (wait_done) next_state = ctrl_pkg::INIT_PRECHARGE;
            ctrl_pkg::INIT_PRECHARGE: if (wait_done) next_state = ctrl_pkg::INIT_REFRESH1;
            ctrl_pkg::INIT_REFRESH1:  if (wait_done) next_state = ctrl_pkg::INIT_REFRESH2;
            ctrl_pkg::INIT_REFRESH2:  if (wait_done) next_state = ctrl_pkg::INIT_LMR;
            ctrl_pkg::INIT_LMR:       if (wait_done) next_state = ctrl_pkg::IDLE;
            ctrl_pkg::IDLE: begin
                // Owed refresh goes first
                if (refresh_owed)
                    next_state = ctrl_pkg::REFRESH;
                else if (req)
                    next_state = ctrl_pkg::ACTIVE;
            end
            ctrl_pkg::REFRESH:        if (wait_done) next_state = ctrl_pkg::IDLE;
            ctrl_pkg::ACTIVE: begin
                if (wait_done)
                    next_state = cur.wr ? ctrl_pkg::WRITE : ctrl_pkg::READ;
            end
            ctrl_pkg::READ:           next_state = ctrl_pkg::READ_WAIT;
            ctrl_pkg::WRITE:          next_state = ctrl_pkg::WRITE_RECOVER;
            ctrl_pkg::READ_WAIT:      if (read_done) next_state = ctrl_pkg::PRECHARGE;
            ctrl_pkg::WRITE_RECOVER:  if (wait_done) next_state = ctrl_pkg::PRECHARGE;
            ctrl_pkg::PRECHARGE:      if (wait_done) next_state = ctrl_pkg::IDLE;
            default:                  next_state = ctrl_pkg::IDLE;
        endcase
    end

    // Cycles to stay in the state being entered
    always_comb begin
        case (next_state)
            ctrl_pkg::INIT_PRECHARGE,
            ctrl_pkg::PRECHARGE:     wait_load = ctrl_pkg::wait_t'(ctrl_pkg::T_RP);
            ctrl_pkg::INIT_REFRESH1,
            ctrl_pkg::INIT_REFRESH2,
            ctrl_pkg::REFRESH:       wait_load = ctrl_pkg::wait_t'(ctrl_pkg::T_RFC);
            ctrl_pkg::INIT_LMR:      wait_load = ctrl_pkg::wait_t'(ctrl_pkg::T_MRD);
            ctrl_pkg::ACTIVE:        wait_load = ctrl_pkg::wait_t'(ctrl_pkg::T_RCD);
            // WRITE itself already counts as one cycle of tWR
            ctrl_pkg::WRITE_RECOVER: wait_load = ctrl_pkg::wait_t'(ctrl_pkg::T_WR - 1);
            default:                 wait_load = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ctrl_pkg::INIT_WAIT;
            wait_cnt  <= ctrl_pkg::wait_t'(ctrl_pkg::T_INIT_WAIT);
            first     <= 1'b0;
            init_done <= 1'b0;
            row_open  <= 1'b0;
        end else begin
            state <= next_state;
            first <= (next_state != state);
            if (next_state != state)
                wait_cnt <= wait_load;
            else if (wait_cnt != '0)
                wait_cnt <= wait_cnt - 1'b1;
            if (state == ctrl_pkg::INIT_LMR && wait_done)
                init_done <= 1'b1;
            if (next_pins.cmd == sdram_pkg::ACTIVE)
                row_open <= 1'b1;
            else if (next_pins.cmd == sdram_pkg::PRECHARGE)
                row_open <= 1'b0;
        end
    end

    // Copy of the held request, taken as the access starts
    always_ff @(posedge clk) begin
        if (state == ctrl_pkg::IDLE && next_state == ctrl_pkg::ACTIVE)
            cur <= request;
    end

    // ------------------------------------------------------------------
    // Pin command issued on the first cycle of each state
    // ------------------------------------------------------------------
    always_comb begin
        next_pins = '{cke: 1'b1, cmd: sdram_pkg::NOP, ba: '0, a: '0};
        if (first) begin
            case (state)
                ctrl_pkg::INIT_PRECHARGE,
                ctrl_pkg::PRECHARGE: begin
                    next_pins.cmd                  = sdram_pkg::PRECHARGE;
                    next_pins.a.col.auto_precharge = 1'b1;
                end
                ctrl_pkg::INIT_REFRESH1,
                ctrl_pkg::INIT_REFRESH2,
                ctrl_pkg::REFRESH: begin
                    next_pins.cmd = sdram_pkg::AUTO_REFRESH;
                end
                ctrl_pkg::INIT_LMR: begin
                    next_pins.cmd    = sdram_pkg::LOAD_MODE;
                    next_pins.a.mode = sdram_pkg::MODE_WORD;
                end
                ctrl_pkg::ACTIVE: begin
                    next_pins.cmd   = sdram_pkg::ACTIVE;
                    next_pins.ba    = cur.addr.bank;
                    next_pins.a.row = cur.addr.row;
                end
                ctrl_pkg::READ,
                ctrl_pkg::WRITE: begin
                    next_pins.cmd = (state == ctrl_pkg::READ) ? sdram_pkg::READ :
                                                                sdram_pkg::WRITE;
                    next_pins.ba        = cur.addr.bank;
                    next_pins.a.col.col = cur.addr.col;
                end
                default: ;
            endcase
        end
    end

    assign issue_read    = first && (state == ctrl_pkg::READ);
    assign drive_dq      = first && (state == ctrl_pkg::WRITE);
    assign refresh_taken = first && (state == ctrl_pkg::REFRESH);
    assign write_data    = cur.wr_data;

    // Column access only while a row is open
    a_rw_in_window: assert property (@(posedge clk) disable iff (reset)
        (next_pins.cmd inside {sdram_pkg::READ, sdram_pkg::WRITE}) |-> row_open);
    // ACTIVE only after PRECHARGE
    a_active_closed: assert property (@(posedge clk) disable iff (reset)
        (next_pins.cmd == sdram_pkg::ACTIVE) |-> !row_open);

    // Refresh needs one owed and every row closed
    a_refresh_owed_closed: assert property (@(posedge clk) disable iff (reset)
        refresh_taken |-> (refresh_owed && !row_open));

endmodule

// ==== verilog/sdram_refresh_timer.sv ====
// ----------------------------------------------------------------------
// Refresh demand for the sequencer
// Counts the refresh interval after init and keeps a count of owed
// AUTO REFRESH commands, one removed per refresh_taken pulse
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sdram_refresh_timer (
    input  logic clk,
    input  logic reset,
    input  logic init_done,
    input  logic refresh_taken,
    output logic refresh_owed
);

    ctrl_pkg::ref_cnt_t  interval_cnt;
    ctrl_pkg::ref_pend_t pend_cnt;
    logic                expire;

    assign expire       = init_done && (interval_cnt == '0);
    assign refresh_owed = (pend_cnt != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interval_cnt <= ctrl_pkg::ref_cnt_t'(ctrl_pkg::T_REF_INTERVAL - 1);
            pend_cnt     <= '0;
        end else if (!init_done) begin
            // Refreshes in the init sequence cover this period
            interval_cnt <= ctrl_pkg::ref_cnt_t'(ctrl_pkg::T_REF_INTERVAL - 1);
            pend_cnt     <= '0;
        end else begin
            if (expire)
                interval_cnt <= ctrl_pkg::ref_cnt_t'(ctrl_pkg::T_REF_INTERVAL - 1);
            else
                interval_cnt <= interval_cnt - 1'b1;

            case ({expire, refresh_taken})
                2'b10:   pend_cnt <= pend_cnt + 1'b1;
                2'b01:   pend_cnt <= pend_cnt - 1'b1;
                default: pend_cnt <= pend_cnt;
            endcase
        end
    end

    // Sequencer must keep up, owed count may not overflow
    a_pend_no_wrap: assert property (@(posedge clk) disable iff (reset)
        (expire && !refresh_taken) |-> (pend_cnt != '1));

endmodule

// ==== verilog/ctrl_pkg.sv ====
// ----------------------------------------------------------------------
// Controller side definitions: host request, timing and FSM states
// Timing values are in clock cycles of the controller clock
// ----------------------------------------------------------------------
package ctrl_pkg;

    typedef struct packed {
        logic [sdram_pkg::ROW_W-1:0]  row;
        logic [sdram_pkg::BANK_W-1:0] bank;
        logic [sdram_pkg::COL_W-1:0]  col;
    } host_addr_t;

    typedef struct packed {
        logic                          wr;
        host_addr_t                    addr;
        logic [sdram_pkg::DATA_W-1:0]  wr_data;
    } host_req_t;

    // Power-up wait, short so simulation stays quick
    localparam int T_INIT_WAIT    = 200;
    localparam int T_RP           = 3;
    localparam int T_RFC          = 8;
    localparam int T_MRD          = 2;
    localparam int T_RCD          = 3;
    localparam int T_WR           = 2;
    localparam int T_REF_INTERVAL = 390;

    localparam int REF_PEND_W = 4;
    localparam int WAIT_W     = $clog2(T_INIT_WAIT + 1);

    typedef logic [WAIT_W-1:0]                    wait_t;
    typedef logic [REF_PEND_W-1:0]                ref_pend_t;
    typedef logic [$clog2(T_REF_INTERVAL)-1:0]    ref_cnt_t;

    typedef enum logic [3:0] {
        INIT_WAIT, INIT_PRECHARGE, INIT_REFRESH1, INIT_REFRESH2, INIT_LMR,
        IDLE, REFRESH, ACTIVE, READ, WRITE, READ_WAIT, WRITE_RECOVER,
        PRECHARGE
    } seq_state_e;

endpackage

// ==== verilog/sdram_pkg.sv ====
// ----------------------------------------------------------------------
// Device side definitions for a 16-bit, 4-bank SDR SDRAM
// Command codes, the A bus views and the registered pin bundle
// Referenced with sdram_pkg:: from the controller RTL and the testbench
// ----------------------------------------------------------------------
package sdram_pkg;

    // Geometry
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int BANK_W = 2;
    localparam int DATA_W = 16;
    localparam int A_W    = 13;

    localparam int CAS_LATENCY = 2;

    // Each code is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        INHIBIT      = 4'b1111,
        NOP          = 4'b0111,
        ACTIVE       = 4'b0011,
        READ         = 4'b0101,
        WRITE        = 4'b0100,
        PRECHARGE    = 4'b0010,
        AUTO_REFRESH = 4'b0001,
        LOAD_MODE    = 4'b0000
    } sdram_cmd_e;

    // A bus during LOAD MODE REGISTER
    typedef struct packed {
        logic [2:0] reserved;
        logic       wr_burst_mode;
        logic [1:0] op_mode;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_len;
    } mode_word_t;

    // A bus during READ, WRITE and PRECHARGE
    typedef struct packed {
        logic [1:0]       unused_hi;
        logic             auto_precharge;
        logic             unused;
        logic [COL_W-1:0] col;
    } col_word_t;

    // Same 13 pins, meaning picked by the command
    typedef union packed {
        mode_word_t       mode;
        col_word_t        col;
        logic [ROW_W-1:0] row;
    } sdram_a_u;

    typedef struct packed {
        logic              cke;
        sdram_cmd_e        cmd;
        logic [BANK_W-1:0] ba;
        sdram_a_u          a;
    } sdram_pins_t;

    // Burst of one, sequential, single-location writes
    localparam mode_word_t MODE_WORD = '{
        reserved:      3'b000,
        wr_burst_mode: 1'b1,
        op_mode:       2'b00,
        cas_latency:   3'(CAS_LATENCY),
        burst_type:    1'b0,
        burst_len:     3'b000
    };

endpackage
